/* logic/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

	// Data beat width in bytes, data bus is 8 times this
	localparam int BUS_BYTES = 4;

	// AXI3 style burst length field
	localparam int LEN_W = 4;
	localparam int SIZE_W = 3;

	// Largest size code the master accepts, 4 bytes per beat
	localparam logic [SIZE_W-1:0] MAX_SIZE = 3'd2;

	// Burst types, code 3 is reserved
	localparam logic [1:0] BURST_FIXED = 2'd0;
	localparam logic [1:0] BURST_INCR = 2'd1;
	localparam logic [1:0] BURST_WRAP = 2'd2;

	// Anything other than OKAY is treated as an error
	localparam logic [1:0] RESP_OKAY = 2'd0;

endpackage

`default_nettype wire

/* logic/rd_cmd_if.sv */
`default_nettype none

interface rd_cmd_if #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
);

	// One cycle pulse, the fields below hold until the next pulse
	logic valid;
	logic [ADDR_W-1:0] addr;
	logic [ID_W-1:0] id;
	logic [axi_rd_pkg::LEN_W-1:0] len;
	logic [axi_rd_pkg::SIZE_W-1:0] size;
	logic [1:0] burst;

	// Wrap block size in bytes minus one
	logic [ADDR_W-1:0] wrap_mask;

	modport source (
		output valid, addr, id, len, size, burst, wrap_mask
	);

	modport exec (
		input valid, addr, id, len, size, burst
	);

	modport store (
		input valid, addr, size, burst, wrap_mask
	);

endinterface

`default_nettype wire

/* logic/rd_request_decode.sv */
`default_nettype none

module rd_request_decode #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic req_start,
	input wire logic [ADDR_W-1:0] req_addr,
	input wire logic [ID_W-1:0] req_id,
	input wire logic [axi_rd_pkg::LEN_W-1:0] req_len,
	input wire logic [axi_rd_pkg::SIZE_W-1:0] req_size,
	input wire logic [1:0] req_burst,
	input wire logic done,
	output logic busy,
	output logic req_reject,
	rd_cmd_if.source cmd
);

	logic busy_q;
	logic size_ok;
	logic burst_ok;
	logic wrap_len_ok;
	logic legal;
	logic accept;
	logic [ADDR_W-1:0] block_bytes;

	// Busy drops together with done so a new start can be taken right away
	assign busy = busy_q && !done;

	assign size_ok = req_size <= axi_rd_pkg::MAX_SIZE;
	assign burst_ok = (req_burst == axi_rd_pkg::BURST_FIXED) ||
		(req_burst == axi_rd_pkg::BURST_INCR) ||
		(req_burst == axi_rd_pkg::BURST_WRAP);
	assign wrap_len_ok = (req_burst != axi_rd_pkg::BURST_WRAP) ||
		(req_len == 4'd1) || (req_len == 4'd3) ||
		(req_len == 4'd7) || (req_len == 4'd15);
	assign legal = size_ok && burst_ok && wrap_len_ok;
	assign accept = req_start && !busy && legal;

	// Beats in the burst times bytes per beat
	assign block_bytes = (ADDR_W'(req_len) + ADDR_W'(1)) << req_size;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			busy_q <= 1'b0;
			cmd.valid <= 1'b0;
			req_reject <= 1'b0;
		end else begin
			cmd.valid <= accept;
			req_reject <= req_start && !busy && !legal;
			if (accept) begin
				busy_q <= 1'b1;
			end else if (done) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.addr <= req_addr;
			cmd.id <= req_id;
			cmd.len <= req_len;
			cmd.size <= req_size;
			cmd.burst <= req_burst;
			cmd.wrap_mask <= block_bytes - ADDR_W'(1);
		end
	end

	// Done only ever closes a command that is still in flight
	assert property (@(posedge clk) disable iff (!resetn)
		done |-> busy_q);

endmodule

`default_nettype wire

/* logic/rd_channel_execute.sv */
`default_nettype none

module rd_channel_execute #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4
) (
	input wire logic clk,
	input wire logic resetn,
	rd_cmd_if.exec cmd,
	output logic arvalid,
	input wire logic arready,
	output logic [ADDR_W-1:0] araddr,
	output logic [ID_W-1:0] arid,
	output logic [axi_rd_pkg::LEN_W-1:0] arlen,
	output logic [axi_rd_pkg::SIZE_W-1:0] arsize,
	output logic [1:0] arburst,
	input wire logic rvalid,
	output logic rready,
	input wire logic [8*axi_rd_pkg::BUS_BYTES-1:0] rdata,
	input wire logic [ID_W-1:0] rid,
	input wire logic [1:0] rresp,
	input wire logic rlast,
	output logic beat,
	output logic [8*axi_rd_pkg::BUS_BYTES-1:0] beat_data,
	output logic beat_last,
	output logic done,
	output logic err
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ADDR = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;

	logic [1:0] state;
	logic [1:0] state_next;
	logic err_acc;
	logic beat_bad;

	// Command fields stay put for the whole transaction
	assign araddr = cmd.addr;
	assign arid = cmd.id;
	assign arlen = cmd.len;
	assign arsize = cmd.size;
	assign arburst = cmd.burst;

	assign arvalid = state == S_ADDR;
	assign rready = state == S_DATA;

	assign beat = rvalid && rready;
	assign beat_data = rdata;
	assign beat_last = rlast;

	// Bad response code or a beat that belongs to another ID
	assign beat_bad = (rresp != axi_rd_pkg::RESP_OKAY) || (rid != cmd.id);

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (cmd.valid) begin
					state_next = S_ADDR;
				end
			end
			S_ADDR: begin
				if (arready) begin
					state_next = S_DATA;
				end
			end
			S_DATA: begin
				if (beat && rlast) begin
					state_next = S_IDLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			err_acc <= 1'b0;
			done <= 1'b0;
			err <= 1'b0;
		end else begin
			state <= state_next;
			done <= beat && rlast;
			err <= beat && rlast && (err_acc || beat_bad);
			if (cmd.valid) begin
				err_acc <= 1'b0;
			end else if (beat && beat_bad) begin
				err_acc <= 1'b1;
			end
		end
	end

	// Address fields hold until the slave takes them
	assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> $stable(araddr) && $stable(arid) &&
		$stable(arlen) && $stable(arsize) && $stable(arburst));

endmodule

`default_nettype wire

/* logic/rd_beat_store.sv */
`default_nettype none

module rd_beat_store #(
	parameter int ADDR_W = 32,
	parameter int MEM_AW = 12
) (
	input wire logic clk,
	input wire logic resetn,
	rd_cmd_if.store cmd,
	input wire logic beat,
	input wire logic [8*axi_rd_pkg::BUS_BYTES-1:0] beat_data,
	input wire logic beat_last,
	input wire logic [MEM_AW-1:0] mem_raddr,
	output logic [7:0] mem_rdata
);

	localparam int NB = axi_rd_pkg::BUS_BYTES;

	logic [7:0] mem [2**MEM_AW];

	logic active;
	logic [MEM_AW-1:0] start_addr;
	logic [MEM_AW-1:0] cur_addr;
	logic [MEM_AW-1:0] mask;
	logic [MEM_AW-1:0] base;
	logic [MEM_AW-1:0] step;
	logic [MEM_AW-1:0] next_addr;
	logic [MEM_AW-1:0] lane_addr [NB];
	logic lane_en [NB];

	assign start_addr = cmd.addr[MEM_AW-1:0];
	assign mask = cmd.wrap_mask[MEM_AW-1:0];

	// Aligned wrap block that holds the start address
	assign base = start_addr & ~mask;
	assign step = MEM_AW'(1) << cmd.size;

	always_comb begin
		for (int k = 0; k < NB; k++) begin
			lane_en[k] = k < (1 << cmd.size);
			if (cmd.burst == axi_rd_pkg::BURST_WRAP) begin
				lane_addr[k] = base | ((cur_addr + MEM_AW'(k)) & mask);
			end else begin
				lane_addr[k] = cur_addr + MEM_AW'(k);
			end
		end
	end

	always_comb begin
		case (cmd.burst)
			axi_rd_pkg::BURST_FIXED: next_addr = start_addr;
			axi_rd_pkg::BURST_INCR: next_addr = cur_addr + step;
			axi_rd_pkg::BURST_WRAP: next_addr = base | ((cur_addr + step) & mask);
			default: next_addr = cur_addr;
		endcase
	end

	// Set by a new command and cleared once its last beat is stored
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
		end else if (cmd.valid) begin
			active <= 1'b1;
		end else if (beat && beat_last) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid) begin
			cur_addr <= start_addr;
		end else if (beat) begin
			cur_addr <= next_addr;
		end
	end

	// Low lanes only, narrow beats never use the upper bytes
	always_ff @(posedge clk) begin
		if (beat) begin
			for (int k = 0; k < NB; k++) begin
				if (lane_en[k]) begin
					mem[lane_addr[k]] <= beat_data[8*k +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		mem_rdata <= mem[mem_raddr];
	end

	// Beats only arrive for a command that was loaded and not yet finished
	assert property (@(posedge clk) disable iff (!resetn)
		beat |-> active);

endmodule

`default_nettype wire

/* logic/axi_read_master.sv */
`default_nettype none

module axi_read_master #(
	parameter int ADDR_W = 32,
	parameter int ID_W = 4,
	parameter int MEM_AW = 12
) (
	input wire logic clk,
	input wire logic resetn,

	// Request side
	input wire logic req_start,
	input wire logic [ADDR_W-1:0] req_addr,
	input wire logic [ID_W-1:0] req_id,
	input wire logic [axi_rd_pkg::LEN_W-1:0] req_len,
	input wire logic [axi_rd_pkg::SIZE_W-1:0] req_size,
	input wire logic [1:0] req_burst,
	output logic busy,
	output logic req_reject,

	// AXI read address channel
	output logic arvalid,
	input wire logic arready,
	output logic [ADDR_W-1:0] araddr,
	output logic [ID_W-1:0] arid,
	output logic [axi_rd_pkg::LEN_W-1:0] arlen,
	output logic [axi_rd_pkg::SIZE_W-1:0] arsize,
	output logic [1:0] arburst,

	// AXI read data channel
	input wire logic rvalid,
	output logic rready,
	input wire logic [8*axi_rd_pkg::BUS_BYTES-1:0] rdata,
	input wire logic [ID_W-1:0] rid,
	input wire logic [1:0] rresp,
	input wire logic rlast,

	output logic done,
	output logic err,

	// Local memory read port
	input wire logic [MEM_AW-1:0] mem_raddr,
	output logic [7:0] mem_rdata
);

	logic beat;
	logic [8*axi_rd_pkg::BUS_BYTES-1:0] beat_data;
	logic beat_last;

	rd_cmd_if #(
		.ADDR_W(ADDR_W),
		.ID_W(ID_W)
	) cmd_if ();

	rd_request_decode #(
		.ADDR_W(ADDR_W),
		.ID_W(ID_W)
	) u_decode (
		.clk(clk),
		.resetn(resetn),
		.req_start(req_start),
		.req_addr(req_addr),
		.req_id(req_id),
		.req_len(req_len),
		.req_size(req_size),
		.req_burst(req_burst),
		.done(done),
		.busy(busy),
		.req_reject(req_reject),
		.cmd(cmd_if.source)
	);

	rd_channel_execute #(
		.ADDR_W(ADDR_W),
		.ID_W(ID_W)
	) u_execute (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd_if.exec),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.arid(arid),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rid(rid),
		.rresp(rresp),
		.rlast(rlast),
		.beat(beat),
		.beat_data(beat_data),
		.beat_last(beat_last),
		.done(done),
		.err(err)
	);

	rd_beat_store #(
		.ADDR_W(ADDR_W),
		.MEM_AW(MEM_AW)
	) u_store (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd_if.store),
		.beat(beat),
		.beat_data(beat_data),
		.beat_last(beat_last),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

/* tests/axi_slave_model.sv */
`default_nettype none

module axi_slave_model #(
	parameter int ID_W = 4,
	parameter int SEED = 23
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic arvalid,
	output logic arready,
	input wire logic [ID_W-1:0] arid,
	input wire logic [3:0] arlen,
	output logic rvalid,
	input wire logic rready,
	output logic [31:0] rdata,
	output logic [ID_W-1:0] rid,
	output logic [1:0] rresp,
	output logic rlast
);

	integer seed = SEED;
	int bad_beat;
	bit fault;
	bit bad_id;
	logic [ID_W-1:0] id_q;
	logic [3:0] len_q;

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rid = '0;
		rresp = 2'd0;
		rlast = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (resetn && arvalid) begin
				idle_cycles($random(seed) & 3);
				arready = 1'b1;
				id_q = arid;
				len_q = arlen;
				// Roughly one burst in eight carries one bad beat
				fault = ($random(seed) & 7) == 0;
				bad_id = 1'($random(seed) & 1);
				bad_beat = {$random(seed)} % (int'(len_q) + 1);
				@(posedge clk);
				#1;
				arready = 1'b0;
				for (int i = 0; i <= int'(len_q); i++) begin
					idle_cycles($random(seed) & 3);
					rvalid = 1'b1;
					rdata = $random(seed);
					rlast = i == int'(len_q);
					rresp = (fault && !bad_id && i == bad_beat) ? 2'd2 : 2'd0;
					rid = (fault && bad_id && i == bad_beat) ? ~id_q : id_q;
					@(posedge clk);
					#1;
					rvalid = 1'b0;
					rlast = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_axi_read_master.sv */
`default_nettype none

module tb_axi_read_master;

	localparam int MEM_AW = 12;
	localparam int N_TXN = 54;
	// Up to 16 beats of 5 cycles and 64 readback cycles per transaction
	localparam int LIMIT = N_TXN * (16 * 5 + 64) + 1000;

	logic clk = 1'b0;
	logic resetn;
	logic req_start;
	logic [31:0] req_addr;
	logic [3:0] req_id;
	logic [3:0] req_len;
	logic [2:0] req_size;
	logic [1:0] req_burst;
	logic busy;
	logic req_reject;
	logic arvalid;
	logic arready;
	logic [31:0] araddr;
	logic [3:0] arid;
	logic [3:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [3:0] rid;
	logic [1:0] rresp;
	logic rlast;
	logic done;
	logic err;
	logic [MEM_AW-1:0] mem_raddr;
	logic [7:0] mem_rdata;

	integer seed = 23;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int req_count = 0;
	int ar_count = 0;
	int beats_seen = 0;
	int faults = 0;
	bit exp_err = 1'b0;
	bit in_data = 1'b0;
	bit ar_wait = 1'b0;
	bit done_due = 1'b0;
	logic [31:0] exp_addr = '0;
	logic [3:0] exp_id = '0;
	logic [3:0] exp_len = '0;
	logic [2:0] exp_size = '0;
	logic [1:0] exp_burst = '0;
	logic [7:0] shadow [1 << MEM_AW];

	always #10 clk = ~clk;

	axi_read_master #(
		.ADDR_W(32),
		.ID_W(4),
		.MEM_AW(MEM_AW)
	) u_dut (.*);

	axi_slave_model #(
		.ID_W(4),
		.SEED(23)
	) u_slave (.*);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Local byte address of byte k in beat idx of the current command
	function automatic int byte_addr(input int idx, input int k);
		int nb;
		int blk;
		int s;
		int base;
		int a;
		nb = 1 << exp_size;
		s = int'(exp_addr[MEM_AW-1:0]);
		if (exp_burst == axi_rd_pkg::BURST_FIXED) begin
			a = s + k;
		end else if (exp_burst == axi_rd_pkg::BURST_INCR) begin
			a = s + idx * nb + k;
		end else begin
			blk = (int'(exp_len) + 1) * nb;
			base = s - s % blk;
			a = base + (s - base + idx * nb + k) % blk;
		end
		return a % (1 << MEM_AW);
	endfunction

	// Bus monitor sampled at the falling edge where everything is settled
	initial begin
		forever begin
			@(negedge clk);
			if (resetn) begin
				// Done and err follow the last beat by one cycle
				check("done", 32'(done), 32'(done_due));
				check("err", 32'(err), 32'(done_due && exp_err));
				check("rready", 32'(rready), 32'(in_data));
				if (ar_wait) begin
					check("arvalid", 32'(arvalid), 32'd1);
				end
				if (arvalid) begin
					if (ar_count >= req_count) begin
						$display("arvalid is high while no legal request is waiting");
						errors++;
					end
					check("araddr", araddr, exp_addr);
					check("arid", 32'(arid), 32'(exp_id));
					check("arlen", 32'(arlen), 32'(exp_len));
					check("arsize", 32'(arsize), 32'(exp_size));
					check("arburst", 32'(arburst), 32'(exp_burst));
					if (arready) begin
						ar_count++;
						beats_seen = 0;
						exp_err = 1'b0;
						in_data = 1'b1;
					end
				end
				ar_wait = arvalid && !arready;
				if (rvalid && rready) begin
					for (int k = 0; k < (1 << exp_size); k++) begin
						shadow[byte_addr(beats_seen, k)] = rdata[8*k +: 8];
					end
					if (rresp != axi_rd_pkg::RESP_OKAY || rid != exp_id) begin
						exp_err = 1'b1;
					end
					beats_seen++;
					if (rlast) begin
						in_data = 1'b0;
					end
				end
				done_due = rvalid && rready && rlast;
			end
		end
	end

	task automatic drive_start(input logic [31:0] addr, input logic [3:0] id,
		input logic [3:0] len, input logic [2:0] size, input logic [1:0] burst);
		req_addr = addr;
		req_id = id;
		req_len = len;
		req_size = size;
		req_burst = burst;
		req_start = 1'b1;
		@(posedge clk);
		#1;
		req_start = 1'b0;
	endtask

	// One legal burst with an optional second start while busy and a readback
	task automatic run_burst(input logic [1:0] burst, input bit poke);
		int a;
		exp_len = 4'($random(seed));
		if (burst == axi_rd_pkg::BURST_WRAP) begin
			exp_len = 4'((2 << ($random(seed) & 3)) - 1);
		end
		exp_addr = $random(seed);
		exp_id = 4'($random(seed));
		exp_size = 3'({$random(seed)} % 3);
		exp_burst = burst;
		req_count++;
		drive_start(exp_addr, exp_id, exp_len, exp_size, exp_burst);
		check("busy", 32'(busy), 32'd1);
		check("req_reject", 32'(req_reject), 32'd0);
		if (poke) begin
			drive_start(exp_addr ^ 32'h550, exp_id ^ 4'h5, exp_len, exp_size, exp_burst);
			check("req_reject", 32'(req_reject), 32'd0);
		end else begin
			@(posedge clk);
			#1;
		end
		// The address phase opens two cycles after the start
		check("arvalid", 32'(arvalid), 32'd1);
		while (done !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		check("err", 32'(err), 32'(exp_err));
		check("busy", 32'(busy), 32'd0);
		check("beats", beats_seen, int'(exp_len) + 1);
		if (exp_err) begin
			faults++;
		end
		for (int i = 0; i <= int'(exp_len); i++) begin
			for (int k = 0; k < (1 << exp_size); k++) begin
				a = byte_addr(i, k);
				mem_raddr = MEM_AW'(a);
				@(posedge clk);
				#1;
				check("mem_rdata", 32'(mem_rdata), 32'(shadow[a]));
			end
		end
	endtask

	// Kind 0 is a bad size, 1 a reserved burst and 2 an even WRAP length
	task automatic run_illegal(input int kind);
		logic [2:0] size;
		logic [1:0] burst;
		logic [3:0] len;
		size = 3'd2;
		burst = axi_rd_pkg::BURST_WRAP;
		len = 4'(2 * ($random(seed) & 7));
		if (kind == 0) begin
			size = 3'(3 + ($random(seed) & 3));
			burst = axi_rd_pkg::BURST_INCR;
		end else if (kind == 1) begin
			burst = 2'd3;
		end
		drive_start($random(seed), 4'($random(seed)), len, size, burst);
		check("req_reject", 32'(req_reject), 32'd1);
		check("busy", 32'(busy), 32'd0);
		@(posedge clk);
		#1;
		check("req_reject", 32'(req_reject), 32'd0);
		repeat (3) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic report_test(input string name, input int count, input int err_before);
		$display("test %s: %0d transactions, %0d errors", name, count, errors - err_before);
	endtask

	initial begin
		int e0;
		resetn = 1'b0;
		req_start = 1'b0;
		req_addr = '0;
		req_id = '0;
		req_len = '0;
		req_size = '0;
		req_burst = '0;
		mem_raddr = '0;
		repeat (10) @(posedge clk);
		#1;
		e0 = errors;
		check("arvalid", 32'(arvalid), 32'd0);
		check("rready", 32'(rready), 32'd0);
		check("busy", 32'(busy), 32'd0);
		check("done", 32'(done), 32'd0);
		check("req_reject", 32'(req_reject), 32'd0);
		resetn = 1'b1;
		report_test("reset", 0, e0);

		e0 = errors;
		repeat (12) run_burst(axi_rd_pkg::BURST_INCR, 1'b0);
		report_test("incr bursts", 12, e0);
		e0 = errors;
		repeat (8) run_burst(axi_rd_pkg::BURST_FIXED, 1'b0);
		report_test("fixed bursts", 8, e0);
		e0 = errors;
		repeat (8) run_burst(axi_rd_pkg::BURST_WRAP, 1'b0);
		report_test("wrap bursts", 8, e0);
		e0 = errors;
		for (int n = 0; n < 6; n++) begin
			run_illegal(n % 3);
		end
		report_test("illegal requests", 6, e0);
		e0 = errors;
		faults = 0;
		repeat (16) run_burst(2'({$random(seed)} % 3), 1'b0);
		$display("test slave delays and faults: 16 transactions, %0d faulty, %0d errors",
			faults, errors - e0);
		e0 = errors;
		repeat (4) run_burst(axi_rd_pkg::BURST_INCR, 1'b1);
		report_test("start while busy", 4, e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
logic/axi_rd_pkg.sv
logic/rd_cmd_if.sv
logic/rd_request_decode.sv
logic/rd_channel_execute.sv
logic/rd_beat_store.sv
logic/axi_read_master.sv
tests/axi_slave_model.sv
tests/tb_axi_read_master.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_axi_read_master -f flist.f

out=$(./obj_dir/Vtb_axi_read_master) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS'
